//--- include/sched_consts.svh
////////////////////////////////////////
// warp scheduler constants
// sizes of the warp table, the thread
// masks, the barriers and the pending
// instruction counters
////////////////////////////////////////

`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

`define SCHED_NUM_WARPS     4
`define SCHED_NUM_THREADS   4
`define SCHED_PC_BITS       32
`define SCHED_NUM_BARRIERS  4
`define SCHED_PENDING_BITS  8
`define SCHED_PC_STEP       4

`endif

//--- source/warp_pkg.sv
////////////////////////////////////////
// warp types
// ids, masks, program counters and the
// per-warp table entry
////////////////////////////////////////

`include "sched_consts.svh"

package warp_pkg;

    typedef logic [$clog2(`SCHED_NUM_WARPS)-1:0] wid_t;
    typedef logic [`SCHED_NUM_WARPS-1:0]         wmask_t;
    typedef logic [`SCHED_NUM_THREADS-1:0]       tmask_t;
    typedef logic [`SCHED_PC_BITS-1:0]           pc_t;

    typedef struct packed {
        tmask_t tmask;
        pc_t    pc;
    } warp_entry_t;

endpackage

//--- source/ctl_pkg.sv
////////////////////////////////////////
// scheduler control messages
// strobes from execute, branch and
// decode, and the outgoing warp item
////////////////////////////////////////

`include "sched_consts.svh"

package ctl_pkg;

    typedef logic [$clog2(`SCHED_NUM_BARRIERS)-1:0] bar_id_t;

    typedef struct packed {
        logic              valid;
        warp_pkg::tmask_t  tmask;
    } tmc_t;

    typedef struct packed {
        logic              valid;
        warp_pkg::wmask_t  wmask;
        warp_pkg::pc_t     pc;
    } wspawn_t;

    // size_m1 is the number of participating warps minus one
    typedef struct packed {
        logic              valid;
        logic              is_noop;
        bar_id_t           id;
        warp_pkg::wid_t    size_m1;
    } barrier_t;

    typedef struct packed {
        logic              valid;
        warp_pkg::wid_t    wid;
        tmc_t              tmc;
        wspawn_t           wspawn;
        barrier_t          barrier;
    } warp_ctl_t;

    typedef struct packed {
        logic              valid;
        warp_pkg::wid_t    wid;
        logic              taken;
        warp_pkg::pc_t     dest;
    } branch_t;

    typedef struct packed {
        logic              valid;
        warp_pkg::wid_t    wid;
    } warp_ref_t;

    typedef struct packed {
        warp_pkg::wid_t    wid;
        warp_pkg::tmask_t  tmask;
        warp_pkg::pc_t     pc;
    } sched_item_t;

endpackage

//--- source/warp_state.sv
////////////////////////////////////////
// warp state registers
// active, stalled, thread mask and pc
// of every warp, with all the updates
// from spawn, tmc, barriers, branches,
// picks and accepted items
////////////////////////////////////////

`timescale 1ns/1ps
`include "sched_consts.svh"

module warp_state (
    input  logic                  clk,
    input  logic                  reset,
    input  warp_pkg::pc_t         start_pc,
    input  ctl_pkg::warp_ctl_t    warp_ctl,
    input  ctl_pkg::branch_t      branch,
    input  ctl_pkg::warp_ref_t    decode_unlock,
    input  warp_pkg::wmask_t      bar_release,
    input  ctl_pkg::warp_ref_t    pick,
    input  logic                  sched_valid,
    input  logic                  sched_ready,
    input  ctl_pkg::sched_item_t  sched_data,
    output warp_pkg::wmask_t      ready_wmask,
    output warp_pkg::wmask_t      active_wmask,
    output warp_pkg::warp_entry_t [`SCHED_NUM_WARPS-1:0] warp_table
);

    warp_pkg::wmask_t active_q, active_n;
    warp_pkg::wmask_t stalled_q, stalled_n;
    warp_pkg::warp_entry_t [`SCHED_NUM_WARPS-1:0] table_q, table_n;

    // spawn request, applied one cycle after it is taken
    ctl_pkg::wspawn_t spawn_q;
    warp_pkg::wid_t   spawn_wid;
    logic             is_single_warp;
    logic             out_fire;

    assign out_fire = sched_valid && sched_ready;

    always_comb begin
        active_n  = active_q;
        stalled_n = stalled_q;
        table_n   = table_q;

        if (decode_unlock.valid) begin
            stalled_n[decode_unlock.wid] = 1'b0;
        end

        // spawn only fans out from a lone running warp
        if (spawn_q.valid) begin
            if (is_single_warp) begin
                active_n = active_n | spawn_q.wmask;
                for (int i = 0; i < `SCHED_NUM_WARPS; i++) begin
                    if (spawn_q.wmask[i]) begin
                        table_n[i].pc    = spawn_q.pc;
                        table_n[i].tmask = warp_pkg::tmask_t'(1);
                    end
                end
            end
            stalled_n[spawn_wid] = 1'b0;
        end

        // a zero thread mask retires the warp
        if (warp_ctl.valid && warp_ctl.tmc.valid) begin
            active_n[warp_ctl.wid]      = (warp_ctl.tmc.tmask != '0);
            table_n[warp_ctl.wid].tmask = warp_ctl.tmc.tmask;
            stalled_n[warp_ctl.wid]     = 1'b0;
        end

        stalled_n = stalled_n & ~bar_release;

        if (branch.valid) begin
            if (branch.taken) begin
                table_n[branch.wid].pc = branch.dest;
            end
            stalled_n[branch.wid] = 1'b0;
        end

        // hold the warp until something downstream unlocks it
        if (pick.valid) begin
            stalled_n[pick.wid] = 1'b1;
        end

        if (out_fire) begin
            table_n[sched_data.wid].pc = sched_data.pc + warp_pkg::pc_t'(`SCHED_PC_STEP);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q          <= warp_pkg::wmask_t'(1);
            stalled_q         <= '0;
            table_q           <= '0;
            table_q[0].pc     <= start_pc;
            table_q[0].tmask  <= warp_pkg::tmask_t'(1);
            spawn_q           <= '0;
            spawn_wid         <= '0;
            is_single_warp    <= 1'b1;
        end else begin
            active_q       <= active_n;
            stalled_q      <= stalled_n;
            table_q        <= table_n;
            // exactly one bit set
            is_single_warp <= (active_q != '0) && ((active_q & (active_q - 1'b1)) == '0);
            spawn_q.valid  <= warp_ctl.valid && warp_ctl.wspawn.valid;
            if (warp_ctl.valid && warp_ctl.wspawn.valid) begin
                spawn_q.wmask <= warp_ctl.wspawn.wmask;
                spawn_q.pc    <= warp_ctl.wspawn.pc;
                spawn_wid     <= warp_ctl.wid;
            end
        end
    end

    assign ready_wmask  = active_q & ~stalled_q;
    assign active_wmask = active_q;
    assign warp_table   = table_q;

endmodule

//--- source/barrier_table.sv
////////////////////////////////////////
// local barrier table
// counts arriving warps per barrier and
// releases them all on the last arrival
////////////////////////////////////////

`timescale 1ns/1ps
`include "sched_consts.svh"

module barrier_table (
    input  logic               clk,
    input  logic               reset,
    input  ctl_pkg::warp_ctl_t warp_ctl,
    output warp_pkg::wmask_t   bar_release
);

    warp_pkg::wmask_t [`SCHED_NUM_BARRIERS-1:0] bar_mask;
    warp_pkg::wid_t   [`SCHED_NUM_BARRIERS-1:0] bar_ctr;

    ctl_pkg::barrier_t bar;
    warp_pkg::wmask_t  arrive_bit;
    logic              bar_msg;
    logic              arrive;
    logic              complete;

    assign bar        = warp_ctl.barrier;
    assign arrive_bit = warp_pkg::wmask_t'(1) << warp_ctl.wid;
    assign bar_msg    = warp_ctl.valid && bar.valid;
    assign arrive     = bar_msg && !bar.is_noop;
    // last warp in when the count already reached size_m1
    assign complete   = arrive && (bar_ctr[bar.id] == bar.size_m1);

    assign bar_release = complete ? (bar_mask[bar.id] | arrive_bit) :
                         (bar_msg && bar.is_noop) ? arrive_bit : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_mask <= '0;
            bar_ctr  <= '0;
        end else if (complete) begin
            bar_mask[bar.id] <= '0;
            bar_ctr[bar.id]  <= '0;
        end else if (arrive) begin
            bar_mask[bar.id] <= bar_mask[bar.id] | arrive_bit;
            bar_ctr[bar.id]  <= bar_ctr[bar.id] + 1'b1;
        end
    end

endmodule

//--- source/sched_out.sv
////////////////////////////////////////
// warp select and output buffer
// picks the lowest ready warp and queues
// its item in a two-entry buffer that
// drives the valid/ready output
////////////////////////////////////////

`timescale 1ns/1ps
`include "sched_consts.svh"

module sched_out (
    input  logic                 clk,
    input  logic                 reset,
    input  warp_pkg::wmask_t     ready_wmask,
    input  warp_pkg::warp_entry_t [`SCHED_NUM_WARPS-1:0] warp_table,
    output ctl_pkg::warp_ref_t   pick,
    output logic                 sched_valid,
    input  logic                 sched_ready,
    output ctl_pkg::sched_item_t sched_data
);

    warp_pkg::wid_t       sel_wid;
    ctl_pkg::sched_item_t item;
    ctl_pkg::sched_item_t head_q;
    ctl_pkg::sched_item_t tail_q;
    logic [1:0]           count_q;
    logic                 push;
    logic                 pop;

    // priority encoder, lowest index wins
    always_comb begin
        sel_wid = '0;
        for (int i = `SCHED_NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_wmask[i]) begin
                sel_wid = warp_pkg::wid_t'(i);
            end
        end
    end

    assign item.wid   = sel_wid;
    assign item.tmask = warp_table[sel_wid].tmask;
    assign item.pc    = warp_table[sel_wid].pc;

    assign pop  = sched_valid && sched_ready;
    // a full buffer still takes a pick when the head leaves
    assign push = (ready_wmask != '0) && ((count_q != 2'd2) || pop);

    assign pick.valid = push;
    assign pick.wid   = sel_wid;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (pop && (count_q == 2'd2)) begin
            head_q <= tail_q;
        end else if (push && ((count_q == 2'd0) || ((count_q == 2'd1) && pop))) begin
            head_q <= item;
        end
        if (push && (((count_q == 2'd1) && !pop) || ((count_q == 2'd2) && pop))) begin
            tail_q <= item;
        end
    end

    assign sched_valid = (count_q != 2'd0);
    assign sched_data  = head_q;

endmodule

//--- source/pending_track.sv
////////////////////////////////////////
// pending instruction tracker
// per-warp in-flight counters and the
// registered busy level
////////////////////////////////////////

`timescale 1ns/1ps
`include "sched_consts.svh"

module pending_track (
    input  logic               clk,
    input  logic               reset,
    input  ctl_pkg::warp_ref_t issue,
    input  warp_pkg::wmask_t   commit_wmask,
    input  warp_pkg::wmask_t   active_wmask,
    output logic               busy
);

    logic [`SCHED_NUM_WARPS-1:0][`SCHED_PENDING_BITS-1:0] pending;
    warp_pkg::wmask_t inc;
    warp_pkg::wmask_t nonzero;

    always_comb begin
        for (int i = 0; i < `SCHED_NUM_WARPS; i++) begin
            inc[i]     = issue.valid && (issue.wid == warp_pkg::wid_t'(i));
            nonzero[i] = (pending[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            busy    <= 1'b0;
        end else begin
            // saturate at both ends, issue and commit together cancel
            for (int i = 0; i < `SCHED_NUM_WARPS; i++) begin
                if (inc[i] && !commit_wmask[i] && (pending[i] != '1)) begin
                    pending[i] <= pending[i] + 1'b1;
                end else if (commit_wmask[i] && !inc[i] && nonzero[i]) begin
                    pending[i] <= pending[i] - 1'b1;
                end
            end
            busy <= (active_wmask != '0) || (nonzero != '0);
        end
    end

endmodule

//--- source/warp_sched.sv
////////////////////////////////////////
// warp scheduler top
// joins warp state, barriers, warp
// select and pending tracking
////////////////////////////////////////

`timescale 1ns/1ps
`include "sched_consts.svh"

module warp_sched (
    input  logic                 clk,
    input  logic                 reset,
    input  warp_pkg::pc_t        start_pc,
    input  ctl_pkg::warp_ctl_t   warp_ctl,
    input  ctl_pkg::branch_t     branch,
    input  ctl_pkg::warp_ref_t   decode_unlock,
    input  ctl_pkg::warp_ref_t   issue,
    input  warp_pkg::wmask_t     commit_wmask,
    output logic                 sched_valid,
    input  logic                 sched_ready,
    output ctl_pkg::sched_item_t sched_data,
    output logic                 busy
);

    warp_pkg::wmask_t   ready_wmask;
    warp_pkg::wmask_t   active_wmask;
    warp_pkg::wmask_t   bar_release;
    ctl_pkg::warp_ref_t pick;
    warp_pkg::warp_entry_t [`SCHED_NUM_WARPS-1:0] warp_table;

    warp_state u_warp_state (
        .clk           (clk),
        .reset         (reset),
        .start_pc      (start_pc),
        .warp_ctl      (warp_ctl),
        .branch        (branch),
        .decode_unlock (decode_unlock),
        .bar_release   (bar_release),
        .pick          (pick),
        .sched_valid   (sched_valid),
        .sched_ready   (sched_ready),
        .sched_data    (sched_data),
        .ready_wmask   (ready_wmask),
        .active_wmask  (active_wmask),
        .warp_table    (warp_table)
    );

    barrier_table u_barrier_table (
        .clk         (clk),
        .reset       (reset),
        .warp_ctl    (warp_ctl),
        .bar_release (bar_release)
    );

    sched_out u_sched_out (
        .clk         (clk),
        .reset       (reset),
        .ready_wmask (ready_wmask),
        .warp_table  (warp_table),
        .pick        (pick),
        .sched_valid (sched_valid),
        .sched_ready (sched_ready),
        .sched_data  (sched_data)
    );

    pending_track u_pending_track (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .commit_wmask (commit_wmask),
        .active_wmask (active_wmask),
        .busy         (busy)
    );

endmodule

//--- bench/warp_sched_tb.sv
////////////////////////////////////////
// warp scheduler testbench
// drives spawns, branches, barriers and
// tmc through the scheduler and checks
// every item against a reference model
////////////////////////////////////////

`timescale 1ns/1ps
`include "sched_consts.svh"

module warp_sched_tb;

    localparam int NW = `SCHED_NUM_WARPS;
    // the full sequence needs a few hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 reset;
    warp_pkg::pc_t        start_pc;
    ctl_pkg::warp_ctl_t   warp_ctl;
    ctl_pkg::branch_t     branch;
    ctl_pkg::warp_ref_t   decode_unlock;
    ctl_pkg::warp_ref_t   issue;
    warp_pkg::wmask_t     commit_wmask;
    logic                 sched_valid;
    logic                 sched_ready;
    ctl_pkg::sched_item_t sched_data;
    logic                 busy;

    // reference model of the warp table
    logic                 ref_active [NW];
    warp_pkg::tmask_t     ref_tmask [NW];
    warp_pkg::pc_t        ref_pc [NW];
    int                   ref_pending;
    warp_pkg::wid_t       exp_q [$];
    logic                 gap_en;
    logic                 hold_q;
    ctl_pkg::sched_item_t hold_data;
    int                   cycles = 0;

    warp_sched u_warp_sched (
        .clk           (clk),
        .reset         (reset),
        .start_pc      (start_pc),
        .warp_ctl      (warp_ctl),
        .branch        (branch),
        .decode_unlock (decode_unlock),
        .issue         (issue),
        .commit_wmask  (commit_wmask),
        .sched_valid   (sched_valid),
        .sched_ready   (sched_ready),
        .sched_data    (sched_data),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic ctl_pkg::sched_item_t expected_item(input warp_pkg::wid_t wid);
        ctl_pkg::sched_item_t it;
        it.wid   = wid;
        it.tmask = ref_tmask[wid];
        it.pc    = ref_pc[wid];
        return it;
    endfunction

    function automatic logic expected_busy();
        logic any;
        any = (ref_pending != 0);
        for (int i = 0; i < NW; i++) begin
            any = any | ref_active[i];
        end
        return any;
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_item(input string name, input ctl_pkg::sched_item_t exp,
                              input ctl_pkg::sched_item_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected wid %0d tmask %b pc %h, actual wid %0d tmask %b pc %h",
                     $time, name, exp.wid, exp.tmask, exp.pc, act.wid, act.tmask, act.pc);
            stop_run();
        end
    endtask

    task automatic check_busy(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t busy expected %b actual %b", $time, exp, act);
            stop_run();
        end
    endtask

    task automatic send_ctl(input ctl_pkg::warp_ctl_t msg);
        @(negedge clk);
        warp_ctl = msg;
        @(negedge clk);
        warp_ctl = '0;
    endtask

    task automatic pulse_unlock(input warp_pkg::wid_t wid);
        @(negedge clk);
        decode_unlock.valid = 1'b1;
        decode_unlock.wid   = wid;
        @(negedge clk);
        decode_unlock = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // compares every accepted item and checks that a waiting item holds
    always @(posedge clk) begin
        if (!reset) begin
            if (hold_q && !sched_valid) begin
                $display("sched_valid dropped at %0t before the item was taken", $time);
                stop_run();
            end else if (hold_q) begin
                check_item("sched_data", hold_data, sched_data);
            end
            if (sched_valid && sched_ready) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected item from warp %0d at %0t", sched_data.wid, $time);
                    stop_run();
                end else begin
                    check_item("sched_data", expected_item(exp_q[0]), sched_data);
                    ref_pc[exp_q[0]] = ref_pc[exp_q[0]] + `SCHED_PC_STEP;
                    void'(exp_q.pop_front());
                end
            end
        end
        hold_q    <= !reset && sched_valid && !sched_ready;
        hold_data <= sched_data;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    always @(negedge clk) begin
        sched_ready = gap_en ? (($urandom % 3) != 0) : 1'b1;
    end

    initial begin
        ctl_pkg::warp_ctl_t msg;
        ctl_pkg::branch_t   br;
        warp_pkg::wmask_t   spawn_mask;
        warp_pkg::wid_t     w;
        int                 n_active;
        int                 arrived;

        void'($urandom(39));
        reset         = 1'b1;
        start_pc      = 32'h0000_1000;
        warp_ctl      = '0;
        branch        = '0;
        decode_unlock = '0;
        issue         = '0;
        commit_wmask  = '0;
        sched_ready   = 1'b1;
        gap_en        = 1'b0;
        ref_pending   = 0;
        for (int i = 0; i < NW; i++) begin
            ref_active[i] = (i == 0);
            ref_tmask[i]  = (i == 0) ? warp_pkg::tmask_t'(1) : '0;
            ref_pc[i]     = (i == 0) ? start_pc : '0;
        end
        exp_q.push_back(0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // first item, then one decode unlock
        wait_drain();
        check_busy(expected_busy(), busy);
        exp_q.push_back(0);
        pulse_unlock(0);
        wait_drain();

        // spawn from the lone warp into a random set of warps 1..3
        spawn_mask            = warp_pkg::wmask_t'((($urandom % 7) + 1) << 1);
        msg                   = '0;
        msg.valid             = 1'b1;
        msg.wspawn.valid      = 1'b1;
        msg.wspawn.wmask      = spawn_mask;
        msg.wspawn.pc         = 32'h0000_2000;
        for (int i = 0; i < NW; i++) begin
            if (spawn_mask[i]) begin
                ref_active[i] = 1'b1;
                ref_tmask[i]  = warp_pkg::tmask_t'(1);
                ref_pc[i]     = msg.wspawn.pc;
            end
            if (ref_active[i]) begin
                exp_q.push_back(warp_pkg::wid_t'(i));
            end
        end
        send_ctl(msg);
        wait_drain();

        // random branches on active warps
        repeat (8) begin
            w = warp_pkg::wid_t'($urandom % NW);
            while (!ref_active[w]) begin
                w = w + 1'b1;
            end
            br       = '0;
            br.valid = 1'b1;
            br.wid   = w;
            br.taken = 1'($urandom % 2);
            br.dest  = $urandom & ~32'h3;
            if (br.taken) begin
                ref_pc[w] = br.dest;
            end
            exp_q.push_back(w);
            @(negedge clk);
            branch = br;
            @(negedge clk);
            branch = '0;
            wait_drain();
        end

        // barrier across all active warps, nothing until the last arrival
        n_active = 0;
        for (int i = 0; i < NW; i++) begin
            n_active = n_active + int'(ref_active[i]);
        end
        arrived = 0;
        for (int i = 0; i < NW; i++) begin
            if (ref_active[i]) begin
                msg                     = '0;
                msg.valid               = 1'b1;
                msg.wid                 = warp_pkg::wid_t'(i);
                msg.barrier.valid       = 1'b1;
                msg.barrier.id          = 2'd2;
                msg.barrier.size_m1     = warp_pkg::wid_t'(n_active - 1);
                arrived = arrived + 1;
                if (arrived == n_active) begin
                    for (int j = 0; j < NW; j++) begin
                        if (ref_active[j]) begin
                            exp_q.push_back(warp_pkg::wid_t'(j));
                        end
                    end
                end
                send_ctl(msg);
                repeat (4) @(negedge clk);
            end
        end
        wait_drain();

        // back to back unlocks while ready drops at random
        gap_en = 1'b1;
        repeat (4) begin
            for (int i = 0; i < NW; i++) begin
                if (ref_active[i]) begin
                    @(negedge clk);
                    decode_unlock.valid = 1'b1;
                    decode_unlock.wid   = warp_pkg::wid_t'(i);
                    exp_q.push_back(warp_pkg::wid_t'(i));
                end
            end
            @(negedge clk);
            decode_unlock = '0;
            wait_drain();
        end
        gap_en = 1'b0;

        // pending work keeps busy up after every warp retires
        repeat (3) begin
            @(negedge clk);
            issue.valid = 1'b1;
            issue.wid   = '0;
            ref_pending = ref_pending + 1;
        end
        @(negedge clk);
        issue = '0;
        for (int i = 0; i < NW; i++) begin
            if (ref_active[i]) begin
                msg           = '0;
                msg.valid     = 1'b1;
                msg.wid       = warp_pkg::wid_t'(i);
                msg.tmc.valid = 1'b1;
                ref_active[i] = 1'b0;
                ref_tmask[i]  = '0;
                send_ctl(msg);
            end
        end
        repeat (3) @(negedge clk);
        check_busy(expected_busy(), busy);
        repeat (3) begin
            @(negedge clk);
            commit_wmask = warp_pkg::wmask_t'(1);
            ref_pending  = ref_pending - 1;
        end
        @(negedge clk);
        commit_wmask = '0;
        repeat (3) @(negedge clk);
        check_busy(expected_busy(), busy);
        repeat (20) @(negedge clk);

        if (exp_q.size() == 0 && !sched_valid) begin
            $display("test passed");
            $finish;
        end else begin
            $display("items still outstanding at the end of the run");
            stop_run();
        end
    end

endmodule

//--- list.f
+incdir+include
source/warp_pkg.sv
source/ctl_pkg.sv
source/warp_state.sv
source/barrier_table.sv
source/sched_out.sv
source/pending_track.sv
source/warp_sched.sv
bench/warp_sched_tb.sv

//--- Makefile
# Verilator build, run and lint for the warp scheduler

VERILATOR ?= verilator
TOP       ?= warp_sched_tb
RTL_TOP   ?= warp_sched
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard include/*.svh source/*.sv bench/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
